// ==== common/pio_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// PIO package
// Widths, register map, ID and version constants and the bus word
// union shared by the local bus decoder, execute and readback blocks
//////////////////////////////////////////////////////////////////////

package pio_pkg;

	// Widths
	localparam int lb_width = 32;		// Local bus data
	localparam int adr_width = 4;		// Local bus address
	localparam int in_width = 8;		// Input pins
	localparam int out_width = 8;		// Output pins

	// ID register contents
	localparam logic [7:0] hw_ver_major = 8'd1;
	localparam logic [7:0] hw_ver_minor = 8'd0;
	localparam logic [15:0] id_code = 16'h5049;	// Upper half of ID word

	// Register map
	localparam logic [adr_width-1:0] adr_id = 4'd0;
	localparam logic [adr_width-1:0] adr_ctl = 4'd1;
	localparam logic [adr_width-1:0] adr_sta = 4'd2;
	localparam logic [adr_width-1:0] adr_din = 4'd3;
	localparam logic [adr_width-1:0] adr_evt_re = 4'd4;
	localparam logic [adr_width-1:0] adr_evt_fe = 4'd5;
	localparam logic [adr_width-1:0] adr_dout_set = 4'd6;	// Write sets, read gives dout
	localparam logic [adr_width-1:0] adr_dout_clr = 4'd7;	// Write clears, read gives dout
	localparam logic [adr_width-1:0] adr_dout_tgl = 4'd8;	// Write only
	localparam logic [adr_width-1:0] adr_dout = 4'd9;		// Write only, masked
	localparam logic [adr_width-1:0] adr_msk = 4'd10;		// Write only

	// Control register bit locations
	localparam int ctl_run = 0;
	localparam int ctl_ie = ctl_run + 1;
	localparam int ctl_re_str = ctl_ie + 1;			// Rising edge enables
	localparam int ctl_fe_str = ctl_re_str + in_width;	// Falling edge enables
	localparam int ctl_width = ctl_fe_str + in_width;

	// Status register
	localparam int sta_irq = 0;

	// Read data for addresses without a readable register
	localparam logic [lb_width-1:0] unmapped_word = 32'hdeadcafe;

	// Pin vectors
	typedef logic [in_width-1:0] pio_in_t;
	typedef logic [out_width-1:0] pio_out_t;

	// Bus word, raw or as control register layout
	// Field order follows the ctl_* bit locations, LSB last
	typedef union packed
	{
		logic [lb_width-1:0] raw;
		struct packed
		{
			logic [lb_width-ctl_width-1:0] rsvd;	// Reads zero
			pio_in_t fe;		// Falling edge enable per pin
			pio_in_t re;		// Rising edge enable per pin
			logic ie;			// Interrupt enable
			logic run;			// PIO running
		} ctl;
	} lb_word_u;

endpackage

// ==== common/pio_reg_if.sv ====
//////////////////////////////////////////////////////////////////////
// PIO register access interface
// Registered bus strobes and data plus one-hot register selects
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

interface pio_reg_if;

	logic wr;			// Write strobe, registered
	logic rd;			// Read strobe, registered
	pio_pkg::lb_word_u din;	// Write data, registered

	// One-hot register selects
	logic sel_id;
	logic sel_ctl;
	logic sel_sta;
	logic sel_din;
	logic sel_evt_re;
	logic sel_evt_fe;
	logic sel_set;
	logic sel_clr;
	logic sel_tgl;
	logic sel_dout;
	logic sel_msk;

	modport decode (output wr, rd, din, sel_id, sel_ctl, sel_sta, sel_din, sel_evt_re,
		sel_evt_fe, sel_set, sel_clr, sel_tgl, sel_dout, sel_msk);

	modport execute (input wr, rd, din, sel_id, sel_ctl, sel_sta, sel_din, sel_evt_re,
		sel_evt_fe, sel_set, sel_clr, sel_tgl, sel_dout, sel_msk);

	modport result (input rd, sel_id, sel_ctl, sel_sta, sel_din, sel_evt_re,
		sel_evt_fe, sel_set, sel_clr, sel_tgl, sel_dout, sel_msk);

endinterface

// ==== pio/pio_lb_decode.sv ====
//////////////////////////////////////////////////////////////////////
// PIO local bus decoder
// Registers the bus inputs and decodes the registered address into
// one-hot register selects
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module pio_lb_decode
(
	input logic CLK_IN,
	input logic rst_in,
	input logic [pio_pkg::adr_width-1:0] adr,
	input logic wr,
	input logic rd,
	input pio_pkg::lb_word_u din,
	pio_reg_if.decode bus
);

	logic [pio_pkg::adr_width-1:0] adr_r;	// Registered address

	// Bus input registers, sampled at edge N
	always_ff @(posedge CLK_IN, posedge rst_in)
	begin
		if (rst_in)
		begin
			adr_r <= '0;
			bus.wr <= 1'b0;
			bus.rd <= 1'b0;
			bus.din <= '0;
		end
		else
		begin
			adr_r <= adr;
			bus.wr <= wr;
			bus.rd <= rd;
			bus.din <= din;
		end
	end

	// Address decode
	// Combinational so the selects line up with the registered strobes
	always_comb
	begin
		bus.sel_id = (adr_r == pio_pkg::adr_id);
		bus.sel_ctl = (adr_r == pio_pkg::adr_ctl);
		bus.sel_sta = (adr_r == pio_pkg::adr_sta);
		bus.sel_din = (adr_r == pio_pkg::adr_din);
		bus.sel_evt_re = (adr_r == pio_pkg::adr_evt_re);
		bus.sel_evt_fe = (adr_r == pio_pkg::adr_evt_fe);
		bus.sel_set = (adr_r == pio_pkg::adr_dout_set);
		bus.sel_clr = (adr_r == pio_pkg::adr_dout_clr);
		bus.sel_tgl = (adr_r == pio_pkg::adr_dout_tgl);
		bus.sel_dout = (adr_r == pio_pkg::adr_dout);
		bus.sel_msk = (adr_r == pio_pkg::adr_msk);	// 11 to 15 select nothing
	end

endmodule

// ==== pio/pio_exec.sv ====
//////////////////////////////////////////////////////////////////////
// PIO execute block
// Control and status registers, input sampling with edge events,
// output commands with write mask, and the interrupt
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module pio_exec
(
	input logic CLK_IN,
	input logic rst_in,
	pio_reg_if.execute bus,
	input pio_pkg::pio_in_t pin_in,
	output pio_pkg::lb_word_u ctl_word,
	output pio_pkg::pio_in_t din_word,
	output pio_pkg::pio_in_t evt_re,
	output pio_pkg::pio_in_t evt_fe,
	output pio_pkg::pio_out_t pin_out,
	output logic irq
);

	pio_pkg::lb_word_u ctl_r;		// Control register
	pio_pkg::pio_in_t din_r;		// Current pin sample
	pio_pkg::pio_in_t din_prev_r;	// Previous pin sample
	pio_pkg::pio_in_t edge_re;		// Enabled rising edges
	pio_pkg::pio_in_t edge_fe;		// Enabled falling edges
	pio_pkg::pio_in_t evt_re_r;
	pio_pkg::pio_in_t evt_fe_r;
	pio_pkg::pio_out_t dout_r;		// Output pins
	pio_pkg::pio_out_t msk_r;		// Data write mask
	pio_pkg::pio_out_t wr_bits;		// Write data, pin part
	logic irq_r;
	logic run;
	logic run_nxt;
	logic ie;
	logic wr_ctl;
	logic wr_sta;
	logic wr_set;
	logic wr_clr;
	logic wr_tgl;
	logic wr_dout;
	logic wr_msk;
	logic rd_evt_re;
	logic rd_evt_fe;

	// Qualified strobes
	assign wr_ctl = bus.wr & bus.sel_ctl;
	assign wr_sta = bus.wr & bus.sel_sta;
	assign wr_set = bus.wr & bus.sel_set;
	assign wr_clr = bus.wr & bus.sel_clr;
	assign wr_tgl = bus.wr & bus.sel_tgl;
	assign wr_dout = bus.wr & bus.sel_dout;
	assign wr_msk = bus.wr & bus.sel_msk;
	assign rd_evt_re = bus.rd & bus.sel_evt_re;	// Read clears events
	assign rd_evt_fe = bus.rd & bus.sel_evt_fe;
	assign wr_bits = bus.din.raw[pio_pkg::out_width-1:0];

	// Control register, writable regardless of run
	always_ff @(posedge CLK_IN, posedge rst_in)
	begin
		if (rst_in)
			ctl_r <= '0;
		else if (wr_ctl)
		begin
			ctl_r.ctl.run <= bus.din.ctl.run;
			ctl_r.ctl.ie <= bus.din.ctl.ie;
			ctl_r.ctl.re <= bus.din.ctl.re;
			ctl_r.ctl.fe <= bus.din.ctl.fe;
			ctl_r.ctl.rsvd <= '0;	// Unused bits stay zero
		end
	end

	assign run = ctl_r.ctl.run;
	assign ie = ctl_r.ctl.ie;

	// Run as of the coming edge, pending control write included
	assign run_nxt = wr_ctl ? bus.din.ctl.run : run;

	// Pin sampling, edge M
	always_ff @(posedge CLK_IN, posedge rst_in)
	begin
		if (rst_in)
		begin
			din_r <= '0;
			din_prev_r <= '0;
		end
		else if (run_nxt)
		begin
			din_r <= pin_in;
			din_prev_r <= din_r;
		end
		else
		begin
			din_r <= '0;
			din_prev_r <= '0;
		end
	end

	// Per-bit edge detect, gated by the enables
	assign edge_re = din_r & ~din_prev_r & ctl_r.ctl.re;
	assign edge_fe = ~din_r & din_prev_r & ctl_r.ctl.fe;

	// Event registers, set at M+1
	// A new edge survives a clearing read in the same cycle
	always_ff @(posedge CLK_IN, posedge rst_in)
	begin
		if (rst_in)
		begin
			evt_re_r <= '0;
			evt_fe_r <= '0;
		end
		else if (run_nxt)
		begin
			evt_re_r <= (rd_evt_re ? '0 : evt_re_r) | edge_re;
			evt_fe_r <= (rd_evt_fe ? '0 : evt_fe_r) | edge_fe;
		end
		else
		begin
			evt_re_r <= '0;
			evt_fe_r <= '0;
		end
	end

	// Write mask, all ones again after each data write
	always_ff @(posedge CLK_IN, posedge rst_in)
	begin
		if (rst_in)
			msk_r <= '0;
		else if (!run_nxt)
			msk_r <= '0;
		else if (wr_msk)
			msk_r <= wr_bits;
		else if (wr_dout)
			msk_r <= '1;
	end

	// Output register
	always_ff @(posedge CLK_IN, posedge rst_in)
	begin
		if (rst_in)
			dout_r <= '0;
		else if (!run_nxt)
			dout_r <= '0;
		else if (wr_set)
			dout_r <= dout_r | wr_bits;		// Set ones
		else if (wr_clr)
			dout_r <= dout_r & ~wr_bits;	// Clear ones
		else if (wr_tgl)
			dout_r <= dout_r ^ wr_bits;		// Flip ones
		else if (wr_dout)
			dout_r <= (dout_r & ~msk_r) | (wr_bits & msk_r);
	end

	// Interrupt, one cycle behind the events
	always_ff @(posedge CLK_IN, posedge rst_in)
	begin
		if (rst_in)
			irq_r <= 1'b0;
		else if (!run_nxt)
			irq_r <= 1'b0;
		else if (wr_sta && bus.din.raw[pio_pkg::sta_irq])
			irq_r <= 1'b0;		// Clear wins over set
		else if (ie && ((|evt_re_r) || (|evt_fe_r)))
			irq_r <= 1'b1;
	end

	assign ctl_word = ctl_r;
	assign din_word = din_r;
	assign evt_re = evt_re_r;
	assign evt_fe = evt_fe_r;
	assign pin_out = dout_r;
	assign irq = irq_r;

endmodule

// ==== pio/pio_readback.sv ====
//////////////////////////////////////////////////////////////////////
// PIO readback
// Read data multiplexer and read valid for the local bus
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module pio_readback
(
	input logic CLK_IN,
	input logic rst_in,
	pio_reg_if.result bus,
	input pio_pkg::lb_word_u ctl_word,
	input pio_pkg::pio_in_t din_word,
	input pio_pkg::pio_in_t evt_re,
	input pio_pkg::pio_in_t evt_fe,
	input pio_pkg::pio_out_t pin_out,
	input logic irq,
	output logic [pio_pkg::lb_width-1:0] dout,
	output logic vld
);

	// Read word, zero-extended
	always_comb
	begin
		dout = '0;
		if (bus.sel_id)
			dout = {pio_pkg::id_code, pio_pkg::hw_ver_major, pio_pkg::hw_ver_minor};
		else if (bus.sel_ctl)
			dout[pio_pkg::ctl_width-1:0] = ctl_word.raw[pio_pkg::ctl_width-1:0];
		else if (bus.sel_sta)
			dout[pio_pkg::sta_irq] = irq;
		else if (bus.sel_din)
			dout[pio_pkg::in_width-1:0] = din_word;
		else if (bus.sel_evt_re)
			dout[pio_pkg::in_width-1:0] = evt_re;	// Pre-clear value
		else if (bus.sel_evt_fe)
			dout[pio_pkg::in_width-1:0] = evt_fe;
		else if (bus.sel_set || bus.sel_clr)
			dout[pio_pkg::out_width-1:0] = pin_out;
		else
			dout = pio_pkg::unmapped_word;		// Write-only registers and empty addresses
	end

	// Registered strobe is already one cycle after the sample edge
	assign vld = bus.rd;

endmodule

// ==== hw/pio_top.sv ====
//////////////////////////////////////////////////////////////////////
// PIO top level
// Local bus decode, execute and readback around the register interface
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module pio_top
(
	input logic CLK_IN,
	input logic rst_in,

	// Local bus
	input logic [pio_pkg::adr_width-1:0] lb_adr,
	input logic lb_wr,
	input logic lb_rd,
	input logic [pio_pkg::lb_width-1:0] lb_din,
	output logic [pio_pkg::lb_width-1:0] lb_dout,
	output logic lb_vld,

	// Pins and interrupt
	input pio_pkg::pio_in_t pio_dat_in,
	output pio_pkg::pio_out_t pio_dat_out,
	output logic irq
);

	pio_pkg::lb_word_u ctl_word;
	pio_pkg::pio_in_t din_word;
	pio_pkg::pio_in_t evt_re;
	pio_pkg::pio_in_t evt_fe;
	pio_pkg::pio_out_t pin_out;
	logic irq_int;

	pio_reg_if bus_if ();

	pio_lb_decode decode_i
	(
		.CLK_IN (CLK_IN),
		.rst_in (rst_in),
		.adr (lb_adr),
		.wr (lb_wr),
		.rd (lb_rd),
		.din (lb_din),
		.bus (bus_if.decode)
	);

	pio_exec exec_i
	(
		.CLK_IN (CLK_IN),
		.rst_in (rst_in),
		.bus (bus_if.execute),
		.pin_in (pio_dat_in),
		.ctl_word (ctl_word),
		.din_word (din_word),
		.evt_re (evt_re),
		.evt_fe (evt_fe),
		.pin_out (pin_out),
		.irq (irq_int)
	);

	pio_readback readback_i
	(
		.CLK_IN (CLK_IN),
		.rst_in (rst_in),
		.bus (bus_if.result),
		.ctl_word (ctl_word),
		.din_word (din_word),
		.evt_re (evt_re),
		.evt_fe (evt_fe),
		.pin_out (pin_out),
		.irq (irq_int),
		.dout (lb_dout),
		.vld (lb_vld)
	);

	assign pio_dat_out = pin_out;
	assign irq = irq_int;

endmodule

// ==== test/tb_clkgen.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench clock and reset
// 20 ns clock, reset held high for the first 5 cycles
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_clkgen
(
	output logic CLK_IN,
	output logic rst_in
);

	initial
	begin
		CLK_IN = 1'b0;
		forever
			#10 CLK_IN = ~CLK_IN;	// 20 ns period
	end

	initial
	begin
		rst_in = 1'b1;
		repeat (5) @(posedge CLK_IN);
		#2;
		rst_in = 1'b0;		// Released clear of the edge
	end

endmodule

// ==== test/pio_tb.sv ====
//////////////////////////////////////////////////////////////////////
// PIO testbench
// Directed tests of register access, output commands, masked writes,
// edge events and the interrupt, with a watchdog on the run time
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module pio_tb;

	localparam int test_count = 6;
	localparam int cycle_ns = 20;
	localparam logic [31:0] ctl_mask = 32'h0003ffff;	// 18 control bits

	logic CLK_IN;
	logic rst_in;
	logic [pio_pkg::adr_width-1:0] lb_adr;
	logic lb_wr;
	logic lb_rd;
	logic [31:0] lb_din;
	logic [31:0] lb_dout;
	logic lb_vld;
	pio_pkg::pio_in_t pio_dat_in;
	pio_pkg::pio_out_t pio_dat_out;
	logic irq;
	logic [31:0] lcg_state = 32'he8de;	// LCG seed

	tb_clkgen clkgen_i
	(
		.CLK_IN (CLK_IN),
		.rst_in (rst_in)
	);

	pio_top dut_i
	(
		.CLK_IN (CLK_IN),
		.rst_in (rst_in),
		.lb_adr (lb_adr),
		.lb_wr (lb_wr),
		.lb_rd (lb_rd),
		.lb_din (lb_din),
		.lb_dout (lb_dout),
		.lb_vld (lb_vld),
		.pio_dat_in (pio_dat_in),
		.pio_dat_out (pio_dat_out),
		.irq (irq)
	);

	// Numerical Recipes LCG constants
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic pio_pkg::pio_in_t rand_pins();
		return pio_pkg::pio_in_t'(lcg_next());	// Low byte
	endfunction

	function automatic pio_pkg::lb_word_u to_word(logic [31:0] value);
		pio_pkg::lb_word_u w;
		w.raw = value;
		return w;
	endfunction

	// Control word through the field layout
	function automatic pio_pkg::lb_word_u make_ctl(logic run, logic ie,
		pio_pkg::pio_in_t re, pio_pkg::pio_in_t fe);
		pio_pkg::lb_word_u w;
		w = '0;
		w.ctl.run = run;
		w.ctl.ie = ie;
		w.ctl.re = re;
		w.ctl.fe = fe;
		return w;
	endfunction

	task automatic abort_run();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic abort_with_message(string msg);
		$display("%s", msg);
		abort_run();
	endtask

	task automatic check_word(string name, pio_pkg::lb_word_u exp, pio_pkg::lb_word_u act);
		if (act.raw !== exp.raw)
		begin
			$display("Error %s expected %h actual %h", name, exp.raw, act.raw);
			abort_run();
		end
	endtask

	task automatic check_pins(string name, pio_pkg::pio_out_t exp, pio_pkg::pio_out_t act);
		if (act !== exp)
		begin
			$display("Error %s expected %h actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_irq(string name, logic exp, logic act);
		if (act !== exp)
		begin
			$display("Error %s expected %h actual %h", name, exp, act);
			abort_run();
		end
	endtask

	// n rising edges, then the stable half of the cycle
	task automatic wait_cycles(int n);
		repeat (n) @(posedge CLK_IN);
		@(negedge CLK_IN);
	endtask

	task automatic drive_pins(pio_pkg::pio_in_t pat);
		@(posedge CLK_IN);
		#2;
		pio_dat_in = pat;	// Sampled at the next edge
	endtask

	task automatic lb_write(logic [pio_pkg::adr_width-1:0] adr, logic [31:0] data);
		@(posedge CLK_IN);
		#2;
		lb_adr = adr;
		lb_din = data;
		lb_wr = 1'b1;
		@(posedge CLK_IN);	// Edge N
		#2;
		lb_wr = 1'b0;
	endtask

	task automatic lb_read(input logic [pio_pkg::adr_width-1:0] adr,
		output pio_pkg::lb_word_u data);
		@(posedge CLK_IN);
		#2;
		lb_adr = adr;
		lb_rd = 1'b1;
		@(negedge CLK_IN);
		if (lb_vld)
			abort_with_message("Read valid came before the read strobe was sampled");
		@(posedge CLK_IN);	// Edge N
		#2;
		lb_rd = 1'b0;
		@(negedge CLK_IN);
		if (!lb_vld)
			abort_with_message("No read valid in the cycle after the read strobe");
		data.raw = lb_dout;
		@(negedge CLK_IN);
		if (lb_vld)
			abort_with_message("Read valid stayed high for more than one cycle");
	endtask

	task automatic test_id_unmapped();
		pio_pkg::lb_word_u rd_word;
		lb_read(pio_pkg::adr_id, rd_word);
		check_word("lb_dout id", to_word({pio_pkg::id_code, 8'h01, 8'h00}), rd_word);
		for (int a = 8; a < 16; a++)
		begin
			lb_read(4'(a), rd_word);	// Write-only and empty addresses
			check_word("lb_dout unmapped", to_word(32'hdeadcafe), rd_word);
		end
	endtask

	task automatic test_ctl_run();
		pio_pkg::lb_word_u wr_word;
		pio_pkg::lb_word_u rd_word;
		wr_word.raw = lcg_next();
		lb_write(pio_pkg::adr_ctl, wr_word.raw);
		lb_read(pio_pkg::adr_ctl, rd_word);
		check_word("lb_dout ctl", to_word(wr_word.raw & ctl_mask), rd_word);
		// Stopped, everything enabled otherwise
		lb_write(pio_pkg::adr_ctl, make_ctl(1'b0, 1'b1, 8'hff, 8'hff));
		lb_write(pio_pkg::adr_dout_set, 32'h000000ff);
		wait_cycles(1);
		check_pins("pio_dat_out", 8'h00, pio_dat_out);
		for (int i = 0; i < 4; i++)
			drive_pins(rand_pins());
		wait_cycles(2);
		lb_read(pio_pkg::adr_evt_re, rd_word);
		check_word("lb_dout evt_re", to_word(32'h0), rd_word);
		lb_read(pio_pkg::adr_evt_fe, rd_word);
		check_word("lb_dout evt_fe", to_word(32'h0), rd_word);
		check_irq("irq", 1'b0, irq);
		// Activity, then run cleared
		drive_pins('0);
		lb_write(pio_pkg::adr_ctl, make_ctl(1'b1, 1'b1, 8'hff, 8'h00));
		lb_write(pio_pkg::adr_dout_set, 32'h0000003c);
		drive_pins(8'hff);
		wait_cycles(3);
		check_irq("irq", 1'b1, irq);
		check_pins("pio_dat_out", 8'h3c, pio_dat_out);
		lb_write(pio_pkg::adr_ctl, make_ctl(1'b0, 1'b1, 8'hff, 8'h00));
		wait_cycles(1);
		check_pins("pio_dat_out", 8'h00, pio_dat_out);
		check_irq("irq", 1'b0, irq);
		drive_pins('0);
	endtask

	task automatic test_out_cmds();
		pio_pkg::pio_out_t exp_out;
		pio_pkg::pio_out_t data;
		logic [31:0] wdata;
		pio_pkg::lb_word_u rd_word;
		lb_write(pio_pkg::adr_ctl, make_ctl(1'b1, 1'b0, 8'h00, 8'h00));
		exp_out = '0;		// Zero from the stopped state
		for (int i = 0; i < 9; i++)
		begin
			wdata = lcg_next();
			data = pio_pkg::pio_out_t'(wdata);
			if (i % 3 == 0)
			begin
				lb_write(pio_pkg::adr_dout_set, wdata);
				exp_out = exp_out | data;
			end
			else if (i % 3 == 1)
			begin
				lb_write(pio_pkg::adr_dout_clr, wdata);
				exp_out = exp_out & ~data;
			end
			else
			begin
				lb_write(pio_pkg::adr_dout_tgl, wdata);
				exp_out = exp_out ^ data;
			end
			wait_cycles(1);
			check_pins("pio_dat_out", exp_out, pio_dat_out);
			lb_read(pio_pkg::adr_dout_set, rd_word);
			check_word("lb_dout dout", to_word({24'h0, exp_out}), rd_word);
		end
		lb_read(pio_pkg::adr_dout_clr, rd_word);	// Clear address reads the same
		check_word("lb_dout dout", to_word({24'h0, exp_out}), rd_word);
	endtask

	task automatic test_masked_dout();
		pio_pkg::pio_out_t exp_out;
		pio_pkg::pio_out_t msk;
		logic [31:0] wdata;
		lb_write(pio_pkg::adr_dout_clr, 32'h000000ff);
		wdata = lcg_next();
		lb_write(pio_pkg::adr_dout_set, wdata);
		exp_out = pio_pkg::pio_out_t'(wdata);
		msk = pio_pkg::pio_out_t'(lcg_next());
		lb_write(pio_pkg::adr_msk, {24'h0, msk});
		wdata = lcg_next();
		lb_write(pio_pkg::adr_dout, wdata);
		exp_out = (exp_out & ~msk) | (pio_pkg::pio_out_t'(wdata) & msk);
		wait_cycles(1);
		check_pins("pio_dat_out", exp_out, pio_dat_out);
		wdata = lcg_next();
		lb_write(pio_pkg::adr_dout, wdata);	// Mask back to all ones
		exp_out = pio_pkg::pio_out_t'(wdata);
		wait_cycles(1);
		check_pins("pio_dat_out", exp_out, pio_dat_out);
	endtask

	task automatic test_edge_events();
		pio_pkg::pio_in_t re_en;
		pio_pkg::pio_in_t fe_en;
		pio_pkg::pio_in_t prev;
		pio_pkg::pio_in_t pat;
		pio_pkg::pio_in_t exp_re;
		pio_pkg::pio_in_t exp_fe;
		pio_pkg::lb_word_u rd_word;
		re_en = 8'h6c;		// Bits 2 and 5 see both edges
		fe_en = 8'h36;
		drive_pins('0);
		lb_write(pio_pkg::adr_ctl, make_ctl(1'b1, 1'b0, re_en, fe_en));
		wait_cycles(1);
		prev = '0;
		exp_re = '0;
		exp_fe = '0;
		for (int i = 0; i < 10; i++)
		begin
			pat = rand_pins();
			drive_pins(pat);	// One sample per pattern
			exp_re |= pat & ~prev & re_en;
			exp_fe |= ~pat & prev & fe_en;
			prev = pat;
		end
		lb_read(pio_pkg::adr_evt_re, rd_word);
		check_word("lb_dout evt_re", to_word({24'h0, exp_re}), rd_word);
		lb_read(pio_pkg::adr_evt_re, rd_word);
		check_word("lb_dout evt_re", to_word(32'h0), rd_word);
		lb_read(pio_pkg::adr_evt_fe, rd_word);
		check_word("lb_dout evt_fe", to_word({24'h0, exp_fe}), rd_word);
		lb_read(pio_pkg::adr_evt_fe, rd_word);
		check_word("lb_dout evt_fe", to_word(32'h0), rd_word);
		lb_read(pio_pkg::adr_din, rd_word);
		check_word("lb_dout din", to_word({24'h0, prev}), rd_word);
	endtask

	task automatic test_irq();
		pio_pkg::lb_word_u rd_word;
		lb_write(pio_pkg::adr_ctl, make_ctl(1'b1, 1'b0, 8'h01, 8'h00));
		drive_pins('0);
		wait_cycles(3);
		lb_read(pio_pkg::adr_evt_re, rd_word);	// Flush older events
		lb_read(pio_pkg::adr_evt_fe, rd_word);
		// Interrupt enabled
		lb_write(pio_pkg::adr_ctl, make_ctl(1'b1, 1'b1, 8'h01, 8'h00));
		drive_pins(8'h01);
		wait_cycles(3);
		check_irq("irq", 1'b1, irq);
		lb_read(pio_pkg::adr_evt_re, rd_word);
		check_word("lb_dout evt_re", to_word(32'h1), rd_word);
		wait_cycles(2);
		check_irq("irq", 1'b1, irq);	// Sticky after the event read
		lb_read(pio_pkg::adr_sta, rd_word);
		check_word("lb_dout sta", to_word(32'h1), rd_word);
		lb_write(pio_pkg::adr_sta, 32'h1);
		wait_cycles(1);
		check_irq("irq", 1'b0, irq);
		lb_read(pio_pkg::adr_sta, rd_word);
		check_word("lb_dout sta", to_word(32'h0), rd_word);
		// Interrupt disabled, event still kept
		lb_write(pio_pkg::adr_ctl, make_ctl(1'b1, 1'b0, 8'h01, 8'h00));
		drive_pins('0);
		wait_cycles(2);
		drive_pins(8'h01);
		wait_cycles(3);
		check_irq("irq", 1'b0, irq);
		lb_read(pio_pkg::adr_evt_re, rd_word);
		check_word("lb_dout evt_re", to_word(32'h1), rd_word);
		lb_read(pio_pkg::adr_sta, rd_word);
		check_word("lb_dout sta", to_word(32'h0), rd_word);
	endtask

	// Watchdog, 200 cycles per test
	initial
	begin
		#(test_count * 200 * cycle_ns);
		$display("Timeout: the tests did not finish in time");
		abort_run();
	end

	initial
	begin
		lb_adr = '0;
		lb_wr = 1'b0;
		lb_rd = 1'b0;
		lb_din = '0;
		pio_dat_in = '0;
		@(negedge rst_in);
		test_id_unmapped();
		test_ctl_run();
		test_out_cmds();
		test_masked_dout();
		test_edge_events();
		test_irq();
		$display("Test passed");
		$finish;
	end

endmodule

// ==== sim.f ====
common/pio_pkg.sv
common/pio_reg_if.sv
pio/pio_lb_decode.sv
pio/pio_exec.sv
pio/pio_readback.sv
hw/pio_top.sv
test/tb_clkgen.sv
test/pio_tb.sv

// ==== Makefile ====
SRCS := $(shell cat sim.f)

.PHONY: all run clean

all: run

obj_dir/Vpio_tb: sim.f $(SRCS)
	verilator --binary --timing --top-module pio_tb -f sim.f -o Vpio_tb

run: obj_dir/Vpio_tb
	./obj_dir/Vpio_tb | tee sim.log
	grep -qx "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log
